/* Makefile */
# Verilator build and run of the hps_link testbench

SIM := obj_dir/Vtb_hps_link

.PHONY: all run clean

all: run

$(SIM): flist.f $(wildcard hw/*.sv) $(wildcard tests/*.sv)
	verilator --binary --timing --assert --top-module tb_hps_link -f flist.f

# the log decides pass or fail
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

/* flist.f */
hw/hps_link_pkg.sv
hw/cmd_frame_if.sv
hw/word_counter.sv
hw/frame_fsm.sv
hw/uio_regs.sv
hw/ps2_key_decoder.sv
hw/file_loader.sv
hw/hps_link.sv
tests/tb_hps_link.sv

/* hw/cmd_frame_if.sv */
`default_nettype none

interface cmd_frame_if import hps_link_pkg::*; (
	input logic clk_sys
);

	// window levels
	logic      uio_active;
	logic      fio_active;
	// current frame
	logic      frame_end;
	word_t     cmd;
	word_idx_t word_idx;
	word_t     word;
	logic      word_stb;

	modport fsm (input clk_sys, output uio_active, fio_active, cmd, word_idx, word,
		word_stb, frame_end);

	modport sink (input clk_sys, uio_active, fio_active, cmd, word_idx, word,
		word_stb, frame_end);

endinterface

`default_nettype wire

/* hw/file_loader.sv */
`default_nettype none

module file_loader import hps_link_pkg::*; (
	input  logic       clk_sys,
	input  logic       arst_n,
	cmd_frame_if.sink  frm,
	output logic       ioctl_download,
	output logic       ioctl_wr,
	output word_t      ioctl_index,
	output file_addr_t ioctl_addr,
	output file_byte_t ioctl_dout
);

	logic       data_stb;
	logic       wr_q;
	file_addr_t next_addr;

	assign data_stb = frm.fio_active && frm.word_stb && frm.word_idx != '0;

	////////////////////////////////////////////////////////////
	// download control

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			wr_q           <= 1'b0;
			ioctl_wr       <= 1'b0;
		end else begin
			// write pulse trails the data by one cycle
			wr_q     <= 1'b0;
			ioctl_wr <= wr_q;
			if (data_stb) begin
				case (frm.cmd)
					cmd_file_index: begin
						if (frm.word_idx == 6'd1)
							ioctl_index <= frm.word;
					end
					cmd_file_tx: begin
						if (frm.word_idx == 6'd1)
							ioctl_download <= frm.word != '0;
					end
					cmd_file_tx_dat: begin
						if (ioctl_download)
							wr_q <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// address and data

	always_ff @(posedge clk_sys) begin
		if (data_stb) begin
			case (frm.cmd)
				cmd_file_tx: begin
					if (frm.word_idx == 6'd1) begin
						if (frm.word != '0)
							next_addr <= '0;
						else if (ioctl_download)
							ioctl_addr <= next_addr;
					end else if (frm.word_idx == 6'd2) begin
						ioctl_addr[15:0] <= frm.word;
						next_addr[15:0]  <= frm.word;
					end else if (frm.word_idx == 6'd3) begin
						ioctl_addr[26:16] <= frm.word[10:0];
						next_addr[26:16]  <= frm.word[10:0];
					end
				end
				cmd_file_tx_dat: begin
					if (ioctl_download) begin
						ioctl_addr <= next_addr;
						ioctl_dout <= frm.word[7:0];
						next_addr  <= next_addr + 27'd1;
					end
				end
				default: ;
			endcase
		end
	end

	// a stop frame cannot land between a data word and its write
	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$rose(ioctl_wr) |-> ioctl_download);

endmodule

`default_nettype wire

/* hw/frame_fsm.sv */
`default_nettype none

module frame_fsm import hps_link_pkg::*; (
	input  logic     clk_sys,
	input  logic     arst_n,
	input  logic     io_enable,
	input  logic     fp_enable,
	input  logic     io_strobe,
	input  word_t    io_din,
	cmd_frame_if.fsm frm
);

	frame_state_t state;
	frame_state_t state_nx;
	word_t        cmd;
	word_idx_t    word_idx;
	logic         word_stb;
	logic         frame_end;

	// strobes outside a window are ignored
	assign word_stb  = io_strobe && (io_enable || fp_enable);
	assign frame_end = (state == st_uio_cmd || state == st_uio_data) && !io_enable;

	always_comb begin
		state_nx = state;
		case (state)
			st_idle: begin
				if (io_enable)
					state_nx = word_stb ? st_uio_data : st_uio_cmd;
				else if (fp_enable)
					state_nx = word_stb ? st_fio_data : st_fio_cmd;
			end
			st_uio_cmd: begin
				if (!io_enable)
					state_nx = st_idle;
				else if (word_stb)
					state_nx = st_uio_data;
			end
			st_uio_data: begin
				if (!io_enable)
					state_nx = st_idle;
			end
			st_fio_cmd: begin
				if (!fp_enable)
					state_nx = st_idle;
				else if (word_stb)
					state_nx = st_fio_data;
			end
			st_fio_data: begin
				if (!fp_enable)
					state_nx = st_idle;
			end
			default: state_nx = st_idle;
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			cmd   <= '0;
		end else begin
			state <= state_nx;
			// command held from word 0 until the frame is over
			if (word_stb && word_idx == '0)
				cmd <= io_din;
			else if (state == st_idle)
				cmd <= '0;
		end
	end

	// index is back at 0 from the first idle cycle on
	word_counter i_word_counter (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.clear   (state_nx == st_idle),
		.inc     (word_stb),
		.idx     (word_idx)
	);

	assign frm.uio_active = io_enable;
	assign frm.fio_active = fp_enable;
	assign frm.cmd        = cmd;
	assign frm.word_idx   = word_idx;
	assign frm.word       = io_din;
	assign frm.word_stb   = word_stb;
	assign frm.frame_end  = frame_end;

	// host opens one window at a time
	a_one_window: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(io_enable && fp_enable));

endmodule

`default_nettype wire

/* hw/hps_link.sv */
`default_nettype none

module hps_link import hps_link_pkg::*; (
	input  logic       clk_sys,
	input  logic       arst_n,
	// host bus
	input  logic       io_enable,
	input  logic       fp_enable,
	input  logic       io_strobe,
	input  word_t      io_din,
	output word_t      io_dout,
	// core side
	input  status_t    status_in,
	input  logic       status_set,
	output joy_t       joystick_0,
	output joy_t       joystick_1,
	output status_t    status,
	output key_event_t ps2_key,
	output logic       ioctl_download,
	output logic       ioctl_wr,
	output word_t      ioctl_index,
	output file_addr_t ioctl_addr,
	output file_byte_t ioctl_dout
);

	cmd_frame_if frm (.clk_sys(clk_sys));

	frame_fsm i_frame_fsm (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.io_enable (io_enable),
		.fp_enable (fp_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.frm       (frm.fsm)
	);

	uio_regs i_uio_regs (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.frm        (frm.sink),
		.status_in  (status_in),
		.status_set (status_set),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.io_dout    (io_dout)
	);

	ps2_key_decoder i_ps2_key_decoder (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.frm     (frm.sink),
		.ps2_key (ps2_key)
	);

	file_loader i_file_loader (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.frm            (frm.sink),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

`default_nettype wire

/* hw/hps_link_pkg.sv */
`default_nettype none

package hps_link_pkg;

	////////////////////////////////////////////////////////////
	// widths on the host bus and the core side

	// one host bus word
	typedef logic [15:0]  word_t;
	// word position inside a frame, 0 is the command
	typedef logic [5:0]   word_idx_t;
	typedef logic [31:0]  joy_t;
	typedef logic [127:0] status_t;
	// [10] toggle, [9] pressed, [8] extended, [7:0] code
	typedef logic [10:0]  key_event_t;
	typedef logic [26:0]  file_addr_t;
	typedef logic [7:0]   file_byte_t;

	// index stops here instead of wrapping
	localparam word_idx_t idx_max = 6'd63;

	////////////////////////////////////////////////////////////
	// command codes

	// user-io window
	localparam word_t cmd_joy0       = 16'h0002;
	localparam word_t cmd_joy1       = 16'h0003;
	localparam word_t cmd_ps2_key    = 16'h0005;
	localparam word_t cmd_status     = 16'h001e;
	localparam word_t cmd_status_req = 16'h0029;
	// file window
	localparam word_t cmd_file_tx     = 16'h0053;
	localparam word_t cmd_file_tx_dat = 16'h0054;
	localparam word_t cmd_file_index  = 16'h0055;

	// marks the request counter word for the host
	localparam logic [3:0] req_tag = 4'ha;

	typedef enum logic [2:0] {
		st_idle,
		st_uio_cmd,
		st_uio_data,
		st_fio_cmd,
		st_fio_data
	} frame_state_t;

endpackage

`default_nettype wire

/* hw/ps2_key_decoder.sv */
`default_nettype none

module ps2_key_decoder import hps_link_pkg::*; (
	input  logic       clk_sys,
	input  logic       arst_n,
	cmd_frame_if.sink  frm,
	output key_event_t ps2_key
);

	logic [31:0] key_raw;
	logic        skip;
	logic        key_frame;
	logic        key_cmd_stb;
	logic        key_data_stb;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_low;

	assign key_frame    = frm.cmd == cmd_ps2_key;
	assign key_cmd_stb  = frm.uio_active && frm.word_stb && frm.word_idx == '0
		&& frm.word == cmd_ps2_key;
	assign key_data_stb = frm.uio_active && frm.word_stb && frm.word_idx != '0 && key_frame;

	// newest byte in [7:0], break prefix f0 one byte back
	assign pressed  = key_raw[15:8] != 8'hf0;
	assign extended = pressed ? (key_raw[15:8] == 8'he0) : (key_raw[23:16] == 8'he0);

	always_comb begin
		key_low = {pressed, extended, key_raw[7:0]};
		case (key_raw)
			// print-screen make and break, pause make
			32'he012e07c: key_low = 10'h37c;
			32'h7ce0f012: key_low = 10'h17c;
			32'hf014f077: key_low = 10'h377;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (key_cmd_stb)
			key_raw <= '0;
		else if (key_data_stb && frm.word[15:8] != 8'hff)
			key_raw <= {key_raw[23:0], frm.word[7:0]};
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			skip    <= 1'b0;
			ps2_key <= '0;
		end else if (frm.frame_end) begin
			skip <= 1'b0;
			if (key_frame && !skip)
				ps2_key <= {~ps2_key[10], key_low};
		end else if (key_cmd_stb) begin
			skip <= 1'b0;
		end else if (key_data_stb && frm.word[15:8] == 8'hff) begin
			// host marks the frame as not a key event
			skip <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/uio_regs.sv */
`default_nettype none

module uio_regs import hps_link_pkg::*; (
	input  logic      clk_sys,
	input  logic      arst_n,
	cmd_frame_if.sink frm,
	input  status_t   status_in,
	input  logic      status_set,
	output joy_t      joystick_0,
	output joy_t      joystick_1,
	output status_t   status,
	output word_t     io_dout
);

	logic       data_stb;
	logic       in_block;
	logic [2:0] seg;
	logic       status_set_q;
	logic       set_rise;
	logic [3:0] req_cnt;
	status_t    status_req;

	assign data_stb = frm.uio_active && frm.word_stb && frm.word_idx != '0;
	// words 1 to 8 select one 16-bit slice each
	assign in_block = frm.word_idx <= 6'd8;
	assign seg      = 3'(frm.word_idx - 6'd1);
	assign set_rise = status_set && !status_set_q;

	////////////////////////////////////////////////////////////
	// status-set request from the core

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			status_set_q <= 1'b0;
			req_cnt      <= '0;
		end else begin
			status_set_q <= status_set;
			if (set_rise)
				req_cnt <= req_cnt + 4'd1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (set_rise)
			status_req <= status_in;
	end

	////////////////////////////////////////////////////////////
	// host writes

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (data_stb) begin
			case (frm.cmd)
				cmd_joy0: begin
					if (frm.word_idx == 6'd1)
						joystick_0[15:0] <= frm.word;
					else if (frm.word_idx == 6'd2)
						joystick_0[31:16] <= frm.word;
				end
				cmd_joy1: begin
					if (frm.word_idx == 6'd1)
						joystick_1[15:0] <= frm.word;
					else if (frm.word_idx == 6'd2)
						joystick_1[31:16] <= frm.word;
				end
				cmd_status: begin
					if (in_block)
						status[{seg, 4'b0000} +: 16] <= frm.word;
				end
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// read-back, answers the word just strobed

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			io_dout <= '0;
		end else if (!frm.uio_active) begin
			io_dout <= '0;
		end else if (frm.word_stb) begin
			io_dout <= '0;
			if (frm.word_idx == '0) begin
				if (frm.word == cmd_status_req)
					io_dout <= {8'h00, req_tag, req_cnt};
			end else if (frm.cmd == cmd_status_req && in_block) begin
				// low half first
				io_dout <= status_req[{seg, 4'b0000} +: 16];
			end
		end
	end

endmodule

`default_nettype wire

/* hw/word_counter.sv */
`default_nettype none

module word_counter import hps_link_pkg::*; (
	input  logic      clk_sys,
	input  logic      arst_n,
	input  logic      clear,
	input  logic      inc,
	output word_idx_t idx
);

	// a strobe wins over clear, so a strobe in the first cycle of a window still counts
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			idx <= '0;
		end else if (inc) begin
			if (idx != idx_max)
				idx <= idx + 6'd1;
		end else if (clear) begin
			idx <= '0;
		end
	end

	// long frames park on the last index
	a_no_wrap: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(idx == idx_max && !clear) |=> idx != '0);

endmodule

`default_nettype wire

/* tests/tb_hps_link.sv */
`default_nettype none

module tb_hps_link import hps_link_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// well above the cycles that the tests use
	localparam int max_cycles = 4000;
	localparam int dl_len     = 12;

	logic       clk_sys;
	logic       arst_n;
	logic       io_enable;
	logic       fp_enable;
	logic       io_strobe;
	word_t      io_din;
	word_t      io_dout;
	status_t    status_in;
	logic       status_set;
	joy_t       joystick_0;
	joy_t       joystick_1;
	status_t    status;
	key_event_t ps2_key;
	logic       ioctl_download;
	logic       ioctl_wr;
	word_t      ioctl_index;
	file_addr_t ioctl_addr;
	file_byte_t ioctl_dout;

	int          errors;
	int          cycles;
	logic [31:0] seed;
	logic        key_tog;
	// words of the next frame, command first
	word_t       frame_words[$];
	// io_dout one cycle after each strobe
	word_t       resp_words[$];
	file_byte_t  wr_bytes[$];
	file_addr_t  wr_addrs[$];

	hps_link i_hps_link (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.io_enable      (io_enable),
		.fp_enable      (fp_enable),
		.io_strobe      (io_strobe),
		.io_din         (io_din),
		.io_dout        (io_dout),
		.status_in      (status_in),
		.status_set     (status_set),
		.joystick_0     (joystick_0),
		.joystick_1     (joystick_1),
		.status         (status),
		.ps2_key        (ps2_key),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// write monitor, mid-cycle so the pulse and its data are settled
	always @(negedge clk_sys) begin
		if (ioctl_wr === 1'b1) begin
			wr_bytes.push_back(ioctl_dout);
			wr_addrs.push_back(ioctl_addr);
		end
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < max_cycles) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("run timed out after %0d clock cycles", cycles);
		$display("FAIL: see errors above");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// helpers

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic check_eq(input logic [127:0] got, input logic [127:0] exp,
		input string msg);
		if (got !== exp) begin
			errors++;
			$display("** Error at %0d ns: %s, got %0h expected %0h", $time, msg, got, exp);
		end
	endtask

	task automatic start_frame(input word_t cmd);
		frame_words.delete();
		frame_words.push_back(cmd);
	endtask

	task automatic add_word(input word_t w);
		frame_words.push_back(w);
	endtask

	// one strobe per word with an idle cycle after it
	task automatic drive_frame(input logic file_win);
		int i;
		resp_words.delete();
		@(negedge clk_sys);
		if (file_win)
			fp_enable = 1'b1;
		else
			io_enable = 1'b1;
		for (i = 0; i < frame_words.size(); i++) begin
			@(negedge clk_sys);
			io_strobe = 1'b1;
			io_din    = frame_words[i];
			@(negedge clk_sys);
			io_strobe = 1'b0;
			resp_words.push_back(io_dout);
		end
		@(negedge clk_sys);
		io_enable = 1'b0;
		fp_enable = 1'b0;
		repeat (2) @(negedge clk_sys);
		if (!file_win)
			check_eq(128'(io_dout), 128'(16'h0000), "io_dout idle after frame");
	endtask

	task automatic uio_frame;
		drive_frame(1'b0);
	endtask

	task automatic fio_frame;
		drive_frame(1'b1);
	endtask

	task automatic pulse_status_set(input status_t value);
		@(negedge clk_sys);
		status_in  = value;
		status_set = 1'b1;
		@(negedge clk_sys);
		status_set = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// tests

	task automatic test_joysticks;
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		a = word_t'(lcg_next());
		b = word_t'(lcg_next());
		c = word_t'(lcg_next());
		d = word_t'(lcg_next());
		start_frame(cmd_joy0);
		add_word(a);
		add_word(b);
		uio_frame();
		check_eq(128'(joystick_0), 128'({b, a}), "joystick_0 after 0x02");
		start_frame(cmd_joy1);
		add_word(c);
		add_word(d);
		uio_frame();
		check_eq(128'(joystick_1), 128'({d, c}), "joystick_1 after 0x03");
		check_eq(128'(joystick_0), 128'({b, a}), "joystick_0 kept after 0x03");
	endtask

	task automatic test_status;
		status_t exp;
		word_t   w;
		exp = '0;
		start_frame(cmd_status);
		for (int k = 0; k < 8; k++) begin
			w = word_t'(lcg_next());
			exp[16*k +: 16] = w;
			add_word(w);
		end
		uio_frame();
		check_eq(status, exp, "status after 0x1e");
	endtask

	task automatic test_status_req;
		status_t s1;
		status_t s2;
		s1 = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
		s2 = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
		pulse_status_set(s1);
		pulse_status_set(s2);
		start_frame(cmd_status_req);
		for (int k = 0; k < 8; k++)
			add_word(16'h0000);
		uio_frame();
		// tag a, two requests seen
		check_eq(128'(resp_words[0]), 128'(16'h00a2), "request counter word");
		for (int k = 1; k <= 8; k++)
			check_eq(128'(resp_words[k]), 128'(s2[16*(k-1) +: 16]),
				$sformatf("status request word %0d", k));
	endtask

	// bytes oldest first, packed toward bit 0
	task automatic key_frame_check(input logic [31:0] bytes, input int count,
		input logic [9:0] exp_low, input string name);
		start_frame(cmd_ps2_key);
		for (int i = count - 1; i >= 0; i--)
			add_word({8'h00, bytes[8*i +: 8]});
		uio_frame();
		key_tog = ~key_tog;
		check_eq(128'(ps2_key), 128'({key_tog, exp_low}), name);
	endtask

	task automatic test_ps2_keys;
		key_frame_check(32'h0000001c, 1, 10'h21c, "key 1c pressed");
		key_frame_check(32'h0000f01c, 2, 10'h01c, "key 1c released");
		key_frame_check(32'h0000e075, 2, 10'h375, "extended key 75 pressed");
		key_frame_check(32'he012e07c, 4, 10'h37c, "print-screen pressed");
		start_frame(cmd_ps2_key);
		add_word(16'hff00);
		add_word(16'h0011);
		uio_frame();
		check_eq(128'(ps2_key), 128'({key_tog, 10'h37c}), "skipped frame leaves ps2_key");
	endtask

	task automatic test_download;
		file_byte_t exp_bytes[$];
		word_t      w;
		wr_bytes.delete();
		wr_addrs.delete();
		start_frame(cmd_file_index);
		add_word(16'd3);
		fio_frame();
		check_eq(128'(ioctl_index), 128'(16'd3), "ioctl_index after 0x55");
		start_frame(cmd_file_tx);
		add_word(16'd1);
		fio_frame();
		check_eq(128'(ioctl_download), 128'(1'b1), "ioctl_download after start");
		start_frame(cmd_file_tx_dat);
		for (int i = 0; i < dl_len; i++) begin
			w = word_t'(lcg_next());
			exp_bytes.push_back(w[7:0]);
			add_word(w);
		end
		fio_frame();
		start_frame(cmd_file_tx);
		add_word(16'd0);
		fio_frame();
		check_eq(128'(ioctl_download), 128'(1'b0), "ioctl_download after stop");
		check_eq(128'(ioctl_addr), 128'(dl_len), "ioctl_addr after stop");
		check_eq(128'(wr_bytes.size()), 128'(dl_len), "number of ioctl_wr pulses");
		if (wr_bytes.size() == dl_len) begin
			for (int i = 0; i < dl_len; i++) begin
				check_eq(128'(wr_bytes[i]), 128'(exp_bytes[i]), $sformatf("byte %0d", i));
				check_eq(128'(wr_addrs[i]), 128'(i), $sformatf("address of byte %0d", i));
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		arst_n     = 1'b0;
		io_enable  = 1'b0;
		fp_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		errors     = 0;
		seed       = 32'hea917cc1;
		key_tog    = 1'b0;
		repeat (3) @(negedge clk_sys);
		arst_n = 1'b1;
		@(negedge clk_sys);
		check_eq(128'(io_dout), 128'(16'h0000), "io_dout after reset");
		test_joysticks();
		test_status();
		test_status_req();
		test_ps2_keys();
		test_download();
		$display("tests done, %0d errors", errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire
